/* logic/synctimer_consts.svh */
// widths, fixed-point and gain macros for the timer correction stage
`ifndef SYNCTIMER_CONSTS_SVH
`define SYNCTIMER_CONSTS_SVH

// timer and calculation widths
`define SYNC_TIMER_WIDTH 64
`define SYNC_CALC_WIDTH 32

// fixed point
`define SYNC_ERROR_Q 8
`define SYNC_ERROR_WIDTH (`SYNC_CALC_WIDTH + `SYNC_ERROR_Q)

`define SYNC_PHASE_GAIN 4   // phase gain, 1/2^N
`define SYNC_PERIOD_GAIN 4  // period filter update gain, 1/2^N

`define SYNC_INIT_OVERRIDE 1'b1

// strobe to adjust output
`define SYNC_LATENCY 7

`endif

/* logic/synctimer_pkg.sv */
// package synctimer_pkg: scalar timer types and the stage record structs
`include "synctimer_consts.svh"

package synctimer_pkg;

    typedef logic [`SYNC_TIMER_WIDTH-1:0] timer_t;
    typedef logic signed [`SYNC_TIMER_WIDTH-1:0] diff_t;
    typedef logic [`SYNC_CALC_WIDTH-1:0] calc_t;
    typedef logic signed [`SYNC_CALC_WIDTH-1:0] phase_t;
    typedef logic signed [`SYNC_ERROR_WIDTH-1:0] error_t;
    typedef logic [`SYNC_ERROR_WIDTH-1:0] error_u_t;

    typedef struct packed {
        diff_t limit_min;
        diff_t limit_max;
        phase_t phase_min;
        phase_t phase_max;
    } adjust_params_t;

    typedef struct packed {
        logic valid;
        logic override;
        calc_t local_time;
        calc_t master_time;
    } correction_t;

    // filter state handed to the result stage
    typedef struct packed {
        logic valid;
        logic loaded;
        error_t adjust_period;
        error_t adjust_phase;
        error_t change_period;
        error_t change_phase;
    } filter_t;

    typedef struct packed {
        logic valid;
        calc_t total;   // shift of the local reference
    } change_t;

    typedef struct packed {
        logic valid;
        logic sign;
        error_u_t magnitude;
    } adjust_t;

endpackage

/* logic/synctimer_decode.sv */
// synctimer_decode: override request, limit window check and correction record
`timescale 1ns/1ps
`include "synctimer_consts.svh"

module synctimer_decode (
    input  logic                           clk,
    input  logic                           reset,
    input  synctimer_pkg::adjust_params_t  params,
    input  synctimer_pkg::timer_t          current_time,
    input  synctimer_pkg::timer_t          correct_time,
    input  logic                           correct_override,
    input  logic                           correct_valid,
    output logic                           override_request,
    output synctimer_pkg::correction_t     correction
);

    import synctimer_pkg::*;

    logic override;
    diff_t diff_time;
    logic diff_valid;   // strobe that takes part in the limit check

    assign override = correct_override || override_request;

    always_ff @(posedge clk) begin
        if (reset) begin
            diff_valid <= 1'b0;
            override_request <= `SYNC_INIT_OVERRIDE;
        end else begin
            diff_time <= diff_t'(correct_time - current_time);
            diff_valid <= correct_valid && !override;

            if (correct_valid) begin
                override_request <= 1'b0;
            end
            // out of window wins over the clear
            if (diff_valid) begin
                if (diff_time < params.limit_min || diff_time > params.limit_max) begin
                    override_request <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            correction.valid <= 1'b0;
        end else begin
            correction.valid <= correct_valid;
            correction.override <= override;
            correction.local_time <= calc_t'(current_time);  // low part only
            correction.master_time <= calc_t'(correct_time);
        end
    end

endmodule

/* logic/synctimer_execute.sv */
// synctimer_execute: interval and error stages, phase clamp and period filter
`timescale 1ns/1ps
`include "synctimer_consts.svh"

module synctimer_execute (
    input  logic                           clk,
    input  logic                           reset,
    input  synctimer_pkg::adjust_params_t  params,
    input  synctimer_pkg::correction_t     correction,
    input  synctimer_pkg::change_t         change,
    output synctimer_pkg::filter_t         filter_out
);

    import synctimer_pkg::*;

    // stage 0
    calc_t prev_local_time;
    calc_t prev_master_time;
    logic prev_enable;
    calc_t st0_interval_local;
    calc_t st0_interval_master;
    phase_t st0_error_phase;
    logic st0_enable;
    logic st0_valid;

    // stage 1
    phase_t st1_error_phase;
    phase_t st1_error_period;
    logic st1_enable;
    logic st1_valid;

    // stage 2, fixed point conversion
    error_t st2_phase_fixed;
    error_t st2_error_phase;
    error_t st2_error_period;

    // stage 3
    error_t phase_min_fixed;
    error_t phase_max_fixed;
    error_t st3_error_phase;
    error_t st3_error_period;
    error_t st3_period_step;
    logic st3_enable;
    logic st3_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_enable <= 1'b0;
            st0_enable <= 1'b0;
            st0_valid <= 1'b0;
        end else begin
            st0_valid <= correction.valid;
            if (correction.valid) begin
                prev_enable <= 1'b1;
                st0_enable <= prev_enable && !correction.override;  // no interval across a jump
                prev_master_time <= correction.master_time;
                if (correction.override) begin
                    prev_local_time <= correction.master_time;
                end else begin
                    prev_local_time <= correction.local_time;
                end
                st0_interval_local <= correction.local_time - prev_local_time;
                st0_interval_master <= correction.master_time - prev_master_time;
                st0_error_phase <= phase_t'(correction.master_time - correction.local_time);
            end else if (change.valid) begin
                prev_local_time <= prev_local_time + change.total;  // issued correction
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_enable <= 1'b0;
            st1_valid <= 1'b0;
        end else begin
            st1_valid <= st0_valid;
            if (st0_valid) begin
                st1_error_phase <= st0_error_phase;
                st1_error_period <= phase_t'(st0_interval_master - st0_interval_local);
                st1_enable <= st0_enable;
            end
        end
    end

    assign st2_phase_fixed = error_t'(st1_error_phase) <<< `SYNC_ERROR_Q;
    assign st2_error_phase = st2_phase_fixed >>> `SYNC_PHASE_GAIN;
    assign st2_error_period = error_t'(st1_error_period) <<< `SYNC_ERROR_Q;

    assign phase_min_fixed = error_t'(params.phase_min) <<< `SYNC_ERROR_Q;
    assign phase_max_fixed = error_t'(params.phase_max) <<< `SYNC_ERROR_Q;

    always_ff @(posedge clk) begin
        if (reset) begin
            st3_enable <= 1'b0;
            st3_valid <= 1'b0;
        end else begin
            st3_valid <= st1_valid;
            st3_enable <= st1_enable && st1_valid;
            st3_error_period <= st2_error_period;
            if (st2_error_phase < phase_min_fixed) begin
                st3_error_phase <= phase_min_fixed;
            end else if (st2_error_phase > phase_max_fixed) begin
                st3_error_phase <= phase_max_fixed;
            end else begin
                st3_error_phase <= st2_error_phase;
            end
        end
    end

    assign st3_period_step = st3_error_period >>> `SYNC_PERIOD_GAIN;

    // period low-pass accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            filter_out.valid <= 1'b0;
            filter_out.loaded <= 1'b0;
        end else begin
            filter_out.valid <= st3_valid;
            if (st3_enable) begin
                filter_out.adjust_phase <= st3_error_phase;
                filter_out.change_phase <= st3_error_phase;
                if (filter_out.loaded) begin
                    filter_out.adjust_period <= filter_out.adjust_period + st3_period_step;
                    filter_out.change_period <= st3_period_step;
                end else begin
                    // first measured interval taken whole
                    filter_out.adjust_period <= st3_error_period;
                    filter_out.change_period <= st3_error_period;
                    filter_out.loaded <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/synctimer_result.sv */
// synctimer_result: adjust total, sign/magnitude output and change feedback
`timescale 1ns/1ps
`include "synctimer_consts.svh"

module synctimer_result (
    input  logic                     clk,
    input  logic                     reset,
    input  synctimer_pkg::filter_t   filter_out,
    output synctimer_pkg::adjust_t   adjust,
    output synctimer_pkg::change_t   change
);

    import synctimer_pkg::*;

    error_t st5_adjust_total;
    error_t st5_change_total;
    error_t st5_change_int;
    logic st5_loaded;
    logic st5_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            st5_loaded <= 1'b0;
            st5_valid <= 1'b0;
        end else begin
            st5_adjust_total <= filter_out.adjust_period + filter_out.adjust_phase;
            st5_change_total <= filter_out.change_period + filter_out.change_phase;
            st5_loaded <= filter_out.loaded;
            st5_valid <= filter_out.valid;
        end
    end

    assign st5_change_int = st5_change_total >>> `SYNC_ERROR_Q;  // drop fraction

    always_ff @(posedge clk) begin
        if (reset) begin
            adjust.valid <= 1'b0;
            change.valid <= 1'b0;
        end else begin
            adjust.valid <= st5_valid && st5_loaded;
            change.valid <= st5_valid && st5_loaded;
            if (st5_valid && st5_loaded) begin
                adjust.sign <= st5_adjust_total < 0;
                adjust.magnitude <= (st5_adjust_total < 0) ? error_u_t'(-st5_adjust_total)
                                                           : error_u_t'(st5_adjust_total);
                change.total <= calc_t'(st5_change_int);
            end
        end
    end

endmodule

/* logic/synctimer_adjust.sv */
// synctimer_adjust: top level joining decode, execute and result stages
`timescale 1ns/1ps

module synctimer_adjust (
    input  logic                           clk,
    input  logic                           reset,
    input  synctimer_pkg::adjust_params_t  params,
    input  synctimer_pkg::timer_t          current_time,
    input  synctimer_pkg::timer_t          correct_time,
    input  logic                           correct_override,
    input  logic                           correct_valid,
    output logic                           override_request,
    output synctimer_pkg::adjust_t         adjust
);

    import synctimer_pkg::*;

    correction_t correction;
    filter_t filter_out;
    change_t change;    // fed back to the local reference

    synctimer_decode u_decode (
        .clk              (clk),
        .reset            (reset),
        .params           (params),
        .current_time     (current_time),
        .correct_time     (correct_time),
        .correct_override (correct_override),
        .correct_valid    (correct_valid),
        .override_request (override_request),
        .correction       (correction)
    );

    synctimer_execute u_execute (
        .clk        (clk),
        .reset      (reset),
        .params     (params),
        .correction (correction),
        .change     (change),
        .filter_out (filter_out)
    );

    synctimer_result u_result (
        .clk        (clk),
        .reset      (reset),
        .filter_out (filter_out),
        .adjust     (adjust),
        .change     (change)
    );

endmodule

/* test/synctimer_adjust_props.sv */
// synctimer_adjust_props: output strobe and override request assertions, bound to the top level
`timescale 1ns/1ps
`include "synctimer_consts.svh"

module synctimer_adjust_props (
    input logic clk,
    input logic reset,
    input logic correct_valid,
    input logic adjust_valid,
    input logic override_request
);

    a_adjust_single: assert property (@(posedge clk) disable iff (reset)
        adjust_valid |=> !adjust_valid)
        else $error("adjust.valid high for two cycles in a row");

    // every output strobe traces back to an input strobe
    a_adjust_latency: assert property (@(posedge clk) disable iff (reset)
        adjust_valid |-> $past(correct_valid, `SYNC_LATENCY))
        else $error("adjust.valid without correct_valid at the fixed latency");

    a_request_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> override_request)
        else $error("override_request low in the first cycle after reset");

endmodule

bind synctimer_adjust synctimer_adjust_props u_props (
    .clk              (clk),
    .reset            (reset),
    .correct_valid    (correct_valid),
    .adjust_valid     (adjust.valid),
    .override_request (override_request)
);

/* test/synctimer_adjust_tb.sv */
// testbench with clock, random stimulus, reference model, checks and watchdog
`timescale 1ns/1ps
`include "synctimer_consts.svh"

module synctimer_adjust_tb;

    import synctimer_pkg::*;

    localparam int NUM_STROBES = 80;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_CYCLES = NUM_STROBES * 25 + 200;

    logic clk;
    logic reset;
    adjust_params_t params;
    timer_t current_time;
    timer_t correct_time;
    logic correct_override;
    logic correct_valid;
    logic override_request;
    adjust_t adjust;

    integer seed;
    int cycle;
    int mismatch_count;
    int other_count;
    int drift;
    timer_t now_time;
    logic exp_req;
    int req_clear_at;
    int req_set_at;
    int exp_cycle_q[$];
    logic exp_sign_q[$];
    logic [39:0] exp_mag_q[$];

    // model state
    logic m_prev_enable;
    logic [31:0] m_prev_local;
    logic [31:0] m_prev_master;
    logic m_loaded;
    logic signed [39:0] m_adj_period;
    logic signed [39:0] m_adj_phase;
    logic signed [39:0] m_chg_period;
    logic signed [39:0] m_chg_phase;

    synctimer_adjust u_synctimer_adjust (
        .clk              (clk),
        .reset            (reset),
        .params           (params),
        .current_time     (current_time),
        .correct_time     (correct_time),
        .correct_override (correct_override),
        .correct_valid    (correct_valid),
        .override_request (override_request),
        .adjust           (adjust)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_range(input int lo, input int span);
        return lo + int'($unsigned($random(seed)) % $unsigned(span));
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at cycle %0d: %s", cycle, msg);
        other_count++;
    endtask

    task automatic model_strobe(input timer_t ct, input timer_t mt, input logic ov_in);
        logic override;
        logic enable;
        logic signed [63:0] diff;
        logic [31:0] int_local;
        logic [31:0] int_master;
        logic signed [31:0] phase32;
        logic signed [31:0] period32;
        logic signed [39:0] phase_fix;
        logic signed [39:0] period_fix;
        logic signed [39:0] lo;
        logic signed [39:0] hi;
        logic signed [39:0] total;
        logic signed [39:0] change_fix;
        override = ov_in | exp_req;
        diff = $signed(mt - ct);
        req_clear_at = cycle + 1;
        req_set_at = -1;
        if (!override && (diff < params.limit_min || diff > params.limit_max)) begin
            req_set_at = cycle + 2;
        end
        enable = m_prev_enable && !override;
        int_local = ct[31:0] - m_prev_local;
        int_master = mt[31:0] - m_prev_master;
        phase32 = $signed(mt[31:0] - ct[31:0]);
        period32 = $signed(int_master - int_local);
        m_prev_enable = 1'b1;
        m_prev_master = mt[31:0];
        m_prev_local = override ? mt[31:0] : ct[31:0];  // restart from master time
        phase_fix = 40'(phase32);
        phase_fix = (phase_fix <<< `SYNC_ERROR_Q) >>> `SYNC_PHASE_GAIN;
        period_fix = 40'(period32);
        period_fix = period_fix <<< `SYNC_ERROR_Q;
        lo = 40'(params.phase_min);
        lo = lo <<< `SYNC_ERROR_Q;
        hi = 40'(params.phase_max);
        hi = hi <<< `SYNC_ERROR_Q;
        if (phase_fix < lo) begin
            phase_fix = lo;
        end else if (phase_fix > hi) begin
            phase_fix = hi;
        end
        if (enable) begin
            m_adj_phase = phase_fix;
            m_chg_phase = phase_fix;
            if (m_loaded) begin
                m_chg_period = period_fix >>> `SYNC_PERIOD_GAIN;
                m_adj_period = m_adj_period + m_chg_period;
            end else begin
                m_adj_period = period_fix;
                m_chg_period = period_fix;
                m_loaded = 1'b1;
            end
        end
        if (m_loaded) begin
            total = m_adj_period + m_adj_phase;
            exp_cycle_q.push_back(cycle + `SYNC_LATENCY);
            exp_sign_q.push_back(total < 0);
            exp_mag_q.push_back((total < 0) ? -total : total);
            change_fix = (m_chg_period + m_chg_phase) >>> `SYNC_ERROR_Q;
            m_prev_local = m_prev_local + change_fix[31:0];  // feedback lands before next strobe
        end
    endtask

    task automatic check_outputs();
        if (cycle == req_clear_at) exp_req = 1'b0;
        if (cycle == req_set_at) exp_req = 1'b1;
        check_value("override_request", 64'(override_request), 64'(exp_req));
        if (exp_cycle_q.size() > 0 && exp_cycle_q[0] == cycle) begin
            if (adjust.valid !== 1'b1) begin
                report_error("adjust strobe missing at its expected cycle");
            end else begin
                check_value("adjust.sign", 64'(adjust.sign), 64'(exp_sign_q[0]));
                check_value("adjust.magnitude", 64'(adjust.magnitude), 64'(exp_mag_q[0]));
            end
            void'(exp_cycle_q.pop_front());
            void'(exp_sign_q.pop_front());
            void'(exp_mag_q.pop_front());
        end else if (adjust.valid !== 1'b0) begin
            report_error("adjust strobe at an unexpected time");
        end
    endtask

    task automatic tick(input logic strobe, input logic ov_in, input int offset);
        timer_t mt;
        @(posedge clk);
        now_time = now_time + 64'd1;
        mt = now_time + 64'(drift + offset);
        current_time <= now_time;
        correct_time <= mt;
        correct_valid <= strobe;
        correct_override <= strobe && ov_in;
        if (strobe) model_strobe(now_time, mt, ov_in);
        @(negedge clk);
        check_outputs();
        cycle++;
    endtask

    initial begin
        int gap;
        int kind;
        int offset;
        logic ov_in;
        seed = 32'h48f7;
        {cycle, mismatch_count, other_count, drift} = '0;
        // low word wraps during the run
        now_time = {32'd3, 32'hffff_fe00 - 32'(rand_range(0, 256))};
        reset <= 1'b1;
        current_time <= now_time;
        correct_time <= now_time;
        correct_override <= 1'b0;
        correct_valid <= 1'b0;
        params.limit_min = -64'sd2000;
        params.limit_max = 64'sd2000;
        params.phase_min = -32'sd40;
        params.phase_max = 32'sd40;
        exp_req = 1'b1;
        req_clear_at = -1;
        req_set_at = -1;
        m_prev_enable = 1'b0;
        m_loaded = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (5) tick(1'b0, 1'b0, 0);
        for (int n = 0; n < NUM_STROBES; n++) begin
            kind = rand_range(0, 16);
            if (n == 10) kind = 2;      // phase clamp
            if (n == 20) kind = 0;      // out of window
            if (n == 30) kind = 1;      // forced override
            ov_in = (kind == 1);
            offset = rand_range(-50, 101);
            if (kind == 0) offset = rand_range(2500, 2501);
            if (kind == 2 || kind == 3) offset = rand_range(700, 801);
            if (kind != 1 && kind <= 3 && rand_range(0, 2) == 1) offset = -offset;
            drift = drift + rand_range(0, 4);
            gap = rand_range(10, 11);
            tick(1'b1, ov_in, offset);
            repeat (gap - 1) tick(1'b0, 1'b0, 0);
        end
        repeat (20) tick(1'b0, 1'b0, 0);
        if (exp_cycle_q.size() != 0) report_error("expected adjust strobes never arrived");
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* synctimer_adjust.f */
+incdir+logic
logic/synctimer_pkg.sv
logic/synctimer_decode.sv
logic/synctimer_execute.sv
logic/synctimer_result.sv
logic/synctimer_adjust.sv
test/synctimer_adjust_props.sv
test/synctimer_adjust_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = synctimer_adjust_tb
FILELIST = synctimer_adjust.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
